/* compute_tile.f */
tile_pkg.sv
wb_bus_decode.sv
wb_sram.sv
bootrom.sv
noc_rx_fifo.sv
noc_adapter.sv
compute_tile.sv
tb_clk_gen.sv
tb_compute_tile.sv

/* run.sh */
#!/bin/sh
# Build the compute tile testbench with Verilator, then run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_compute_tile \
   -f compute_tile.f -o sim_tb_compute_tile
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/sim_tb_compute_tile
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit "$status"
fi

exit 0

/* tb_compute_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_compute_tile;

   localparam logic [4:0]  TILE_ID        = 5'd3;
   localparam int          MEM_WORDS      = 256;
   localparam int          RX_DEPTH       = 4;
   localparam int          TIMEOUT_CYCLES = 2000;         // Run needs a few hundred cycles
   localparam logic [31:0] ROM_BASE       = {tile_pkg::ROM_BASE_NIB, 28'h0};

   wire         clk;
   wire         rst_n;
   logic [31:0] wb_adr, wb_dat, wb_rdat;
   logic [3:0]  wb_sel;
   logic        wb_we, wb_cyc, wb_stb, wb_ack, wb_err;
   logic [33:0] noc_in_flit, noc_out_flit;
   logic        noc_in_valid, noc_in_ready, noc_out_valid, noc_out_ready, irq;
   logic [31:0] rng = 32'h63a4;                           // Random state
   logic [33:0] sent_q [$];                               // Flits taken off the output
   int          cycles = 0;

   tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

   compute_tile #(
      .TILE_ID (TILE_ID), .MEM_WORDS (MEM_WORDS), .RX_DEPTH (RX_DEPTH)
   ) dut (
      .clk (clk), .rst_n_i (rst_n),
      .wb_adr_i (wb_adr), .wb_dat_i (wb_dat), .wb_sel_i (wb_sel), .wb_we_i (wb_we),
      .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
      .wb_dat_o (wb_rdat), .wb_ack_o (wb_ack), .wb_err_o (wb_err),
      .noc_in_flit_i (noc_in_flit), .noc_in_valid_i (noc_in_valid),
      .noc_in_ready_o (noc_in_ready),
      .noc_out_flit_o (noc_out_flit), .noc_out_valid_o (noc_out_valid),
      .noc_out_ready_i (noc_out_ready), .irq_o (irq)
   );

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
         $display("*** FAILED ***");
         $fatal(1, "watchdog expired");
      end
   end

   // Mid-cycle look at the handshake that completes on the next rising edge
   always @(negedge clk) begin
      if (rst_n && noc_out_valid && noc_out_ready) begin
         sent_q.push_back(noc_out_flit);
      end
   end

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("MISMATCH time=%0t %s got=%0h exp=%0h", $time, name, got, exp);
         $display("*** FAILED ***");
         $fatal(1, "value check failed");
      end
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] na_addr(input logic [7:0] off);
      return {tile_pkg::NA_BASE_NIB, 20'h0, off};         // Adapter register window
   endfunction

   task automatic bus_start(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
      wb_adr = adr;
      wb_dat = dat;
      wb_sel = sel;
      wb_we  = we;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
   endtask

   task automatic wait_resp(output logic [31:0] rdat, output logic [1:0] resp);
      do begin
         @(posedge clk);
         #1;
      end while (!(wb_ack || wb_err));                   // Ack or err ends the access
      rdat = wb_rdat;
      resp = {wb_ack, wb_err};
   endtask

   task automatic bus_end();
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(posedge clk);                                     // Idle cycle between accesses
      #1;
      check("wb_ack_o", 64'(wb_ack), 64'(0));             // Only one response pulse
      check("wb_err_o", 64'(wb_err), 64'(0));
   endtask

   task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output logic [31:0] rdat,
                            output logic [1:0] resp);
      bus_start(we, adr, dat, sel);
      wait_resp(rdat, resp);
      bus_end();
   endtask

   task automatic write_ok(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
      logic [31:0] rd;
      logic [1:0]  resp;
      bus_cycle(1'b1, adr, dat, sel, rd, resp);
      check("{wb_ack_o,wb_err_o}", 64'(resp), 64'(2'b10));
   endtask

   task automatic read_ok(input logic [31:0] adr, output logic [31:0] rd);
      logic [1:0] resp;
      bus_cycle(1'b0, adr, 32'h0, 4'hF, rd, resp);
      check("{wb_ack_o,wb_err_o}", 64'(resp), 64'(2'b10));
   endtask

   task automatic test_sram();
      logic [31:0] adr [8];
      logic [31:0] dat [8];
      logic [31:0] rd, fresh, merged;
      logic [3:0]  sel;
      for (int i = 0; i < 8; i++) begin
         rng    = xorshift(rng);
         adr[i] = 32'(i * 32) + (rng & 32'h1C);           // Distinct words per slot
         rng    = xorshift(rng);
         dat[i] = rng;
         write_ok(adr[i], dat[i], 4'hF);
      end
      for (int i = 0; i < 8; i++) begin
         read_ok(adr[i], rd);
         check("wb_dat_o", 64'(rd), 64'(dat[i]));
      end
      rng    = xorshift(rng);
      fresh  = rng;
      sel    = 4'b0110;
      merged = {dat[0][31:24], fresh[23:8], dat[0][7:0]}; // Lanes 1 and 2 take new bytes
      write_ok(adr[0], fresh, sel);
      read_ok(adr[0], rd);
      check("wb_dat_o", 64'(rd), 64'(merged));
      rng = xorshift(rng);
      write_ok(adr[1] + 32'(MEM_WORDS * 4), rng, 4'hF);   // One depth up aliases
      read_ok(adr[1], rd);
      check("wb_dat_o", 64'(rd), 64'(rng));
   endtask

   task automatic test_rom();
      logic [31:0] rd;
      for (int i = 0; i < tile_pkg::ROM_WORDS; i++) begin
         read_ok(ROM_BASE + 32'(4 * i), rd);
         check("wb_dat_o", 64'(rd), 64'(tile_pkg::ROM_TABLE[i]));
      end
      read_ok(ROM_BASE + 32'h28, rd);                     // Second copy of word 2
      check("wb_dat_o", 64'(rd), 64'(tile_pkg::ROM_TABLE[2]));
      write_ok(ROM_BASE + 32'h4, ~tile_pkg::ROM_TABLE[1], 4'hF);
      read_ok(ROM_BASE + 32'h4, rd);
      check("wb_dat_o", 64'(rd), 64'(tile_pkg::ROM_TABLE[1]));
   endtask

   task automatic test_unmapped();
      logic [31:0] rd;
      logic [1:0]  resp;
      bus_cycle(1'b0, 32'h9000_0010, 32'h0, 4'hF, rd, resp);
      check("{wb_ack_o,wb_err_o}", 64'(resp), 64'(2'b01));
      bus_cycle(1'b1, 32'h9ABC_0004, 32'h1234_5678, 4'hF, rd, resp);
      check("{wb_ack_o,wb_err_o}", 64'(resp), 64'(2'b01));
      write_ok(32'h0000_0040, 32'h5A5A_0F0F, 4'hF);       // Bus still usable
      read_ok(32'h0000_0040, rd);
      check("wb_dat_o", 64'(rd), 64'(32'h5A5A_0F0F));
   endtask

   task automatic test_send();
      logic [31:0] hdr_w, exp_hdr, d1, d2, rd;
      logic [1:0]  resp;
      sent_q.delete();
      rng     = xorshift(rng);
      hdr_w   = rng;
      exp_hdr = {hdr_w[31:24], TILE_ID, hdr_w[18:0]};    // Src field overwritten
      rng     = xorshift(rng);
      d1      = rng;
      rng     = xorshift(rng);
      d2      = rng;
      write_ok(na_addr(tile_pkg::REG_SEND_HDR), hdr_w, 4'hF);
      write_ok(na_addr(tile_pkg::REG_SEND_DATA), d1, 4'hF);
      write_ok(na_addr(tile_pkg::REG_SEND_LAST), d2, 4'hF);
      check("flits sent", 64'(sent_q.size()), 64'(3));
      check("noc_out_flit_o", 64'(sent_q[0]), 64'({tile_pkg::FLIT_HEADER, exp_hdr}));
      check("noc_out_flit_o", 64'(sent_q[1]), 64'({tile_pkg::FLIT_PAYLOAD, d1}));
      check("noc_out_flit_o", 64'(sent_q[2]), 64'({tile_pkg::FLIT_LAST, d2}));
      sent_q.delete();
      noc_out_ready = 1'b0;                               // Back-pressure from the NoC
      rng = xorshift(rng);
      bus_start(1'b1, na_addr(tile_pkg::REG_SEND_DATA), rng, 4'hF);
      repeat (6) begin
         @(posedge clk);
         #1;
         check("wb_ack_o", 64'(wb_ack), 64'(0));
         check("noc_out_valid_o", 64'(noc_out_valid), 64'(1));
         check("noc_out_flit_o", 64'(noc_out_flit), 64'({tile_pkg::FLIT_PAYLOAD, rng}));
      end
      noc_out_ready = 1'b1;
      wait_resp(rd, resp);
      check("{wb_ack_o,wb_err_o}", 64'(resp), 64'(2'b10));
      bus_end();
      check("noc_out_valid_o", 64'(noc_out_valid), 64'(0));
      check("flits sent", 64'(sent_q.size()), 64'(1));
      check("noc_out_flit_o", 64'(sent_q[0]), 64'({tile_pkg::FLIT_PAYLOAD, rng}));
   endtask

   task automatic test_receive();
      logic [33:0] flits [RX_DEPTH];
      logic [1:0]  ft;
      logic [31:0] rd;
      for (int i = 0; i < RX_DEPTH; i++) begin
         rng = xorshift(rng);
         if (i == 0) begin
            ft = tile_pkg::FLIT_HEADER;
         end else if (i == RX_DEPTH - 1) begin
            ft = tile_pkg::FLIT_LAST;
         end else begin
            ft = tile_pkg::FLIT_PAYLOAD;
         end
         flits[i] = {ft, rng};
         check("noc_in_ready_o", 64'(noc_in_ready), 64'(1));
         noc_in_flit  = flits[i];
         noc_in_valid = 1'b1;
         @(posedge clk);
         #1;
      end
      noc_in_valid = 1'b0;
      noc_in_flit  = '0;
      check("noc_in_ready_o", 64'(noc_in_ready), 64'(0)); // FIFO full
      check("irq_o", 64'(irq), 64'(1));
      read_ok(na_addr(tile_pkg::REG_STATUS), rd);
      check("wb_dat_o", 64'(rd), 64'({22'h0, tile_pkg::FLIT_HEADER, 8'(RX_DEPTH)}));
      for (int i = 0; i < RX_DEPTH; i++) begin
         read_ok(na_addr(tile_pkg::REG_RX_DATA), rd);
         check("wb_dat_o", 64'(rd), 64'(flits[i][31:0]));
      end
      check("irq_o", 64'(irq), 64'(0));
      check("noc_in_ready_o", 64'(noc_in_ready), 64'(1));
      read_ok(na_addr(tile_pkg::REG_RX_DATA), rd);        // Empty FIFO reads zero
      check("wb_dat_o", 64'(rd), 64'(0));
   endtask

   initial begin
      wb_adr        = '0;
      wb_dat        = '0;
      wb_sel        = '0;
      wb_we         = 1'b0;
      wb_cyc        = 1'b0;
      wb_stb        = 1'b0;
      noc_in_flit   = '0;
      noc_in_valid  = 1'b0;
      noc_out_ready = 1'b1;
      wait (rst_n === 1'b1);
      @(posedge clk);
      #1;
      check("wb_ack_o", 64'(wb_ack), 64'(0));             // Idle state after reset
      check("wb_err_o", 64'(wb_err), 64'(0));
      check("noc_out_valid_o", 64'(noc_out_valid), 64'(0));
      check("irq_o", 64'(irq), 64'(0));
      check("noc_in_ready_o", 64'(noc_in_ready), 64'(1));
      test_sram();
      test_rom();
      test_unmapped();
      test_send();
      test_receive();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS    = 10,                       // Clock period
   parameter int RESET_CYCLES = 2                         // Rising edges held in reset
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1 rst_n_o = 1'b1;                                  // Release just after the edge
   end

endmodule

`default_nettype wire

/* compute_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module compute_tile #(
   parameter logic [4:0] TILE_ID   = 5'd3,                // Stamped into header src
   parameter int         MEM_WORDS = 256,                 // SRAM depth, power of two
   parameter int         RX_DEPTH  = 4                    // Receive FIFO depth
) (
   input  wire                          clk,
   input  wire                          rst_n_i,
   input  wire  [tile_pkg::DATA_W-1:0]  wb_adr_i,
   input  wire  [tile_pkg::DATA_W-1:0]  wb_dat_i,
   input  wire  [tile_pkg::SEL_W-1:0]   wb_sel_i,
   input  wire                          wb_we_i,
   input  wire                          wb_cyc_i,
   input  wire                          wb_stb_i,
   output logic [tile_pkg::DATA_W-1:0]  wb_dat_o,
   output logic                         wb_ack_o,
   output logic                         wb_err_o,
   input  wire  [tile_pkg::FLIT_W-1:0]  noc_in_flit_i,
   input  wire                          noc_in_valid_i,
   output logic                         noc_in_ready_o,
   output logic [tile_pkg::FLIT_W-1:0]  noc_out_flit_o,
   output logic                         noc_out_valid_o,
   input  wire                          noc_out_ready_i,
   output logic                         irq_o
);

   logic                        mem_stb, na_stb, rom_stb;   // Per-slave strobes
   logic                        mem_ack, na_ack, rom_ack;   // Per-slave acks
   logic [tile_pkg::DATA_W-1:0] mem_dat, na_dat, rom_dat;   // Per-slave read data

   wb_bus_decode u_bus (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .wb_adr_i  (wb_adr_i),
      .wb_cyc_i  (wb_cyc_i),
      .wb_stb_i  (wb_stb_i),
      .mem_ack_i (mem_ack),
      .mem_dat_i (mem_dat),
      .na_ack_i  (na_ack),
      .na_dat_i  (na_dat),
      .rom_ack_i (rom_ack),
      .rom_dat_i (rom_dat),
      .mem_stb_o (mem_stb),
      .na_stb_o  (na_stb),
      .rom_stb_o (rom_stb),
      .wb_dat_o  (wb_dat_o),
      .wb_ack_o  (wb_ack_o),
      .wb_err_o  (wb_err_o)
   );

   wb_sram #(
      .MEM_WORDS (MEM_WORDS)
   ) u_ram (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .stb_i   (mem_stb),
      .we_i    (wb_we_i),
      .adr_i   (wb_adr_i),                                // Shared request lines
      .dat_i   (wb_dat_i),
      .sel_i   (wb_sel_i),
      .dat_o   (mem_dat),
      .ack_o   (mem_ack)
   );

   noc_adapter #(
      .TILE_ID  (TILE_ID),
      .RX_DEPTH (RX_DEPTH)
   ) u_na (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .stb_i           (na_stb),
      .we_i            (wb_we_i),
      .adr_i           (wb_adr_i),
      .dat_i           (wb_dat_i),
      .dat_o           (na_dat),
      .ack_o           (na_ack),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .irq_o           (irq_o)
   );

   bootrom u_bootrom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .stb_i   (rom_stb),
      .adr_i   (wb_adr_i),
      .dat_o   (rom_dat),
      .ack_o   (rom_ack)
   );

endmodule

`default_nettype wire

/* noc_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_adapter #(
   parameter logic [4:0] TILE_ID  = 5'd3,                 // Own tile number
   parameter int         RX_DEPTH = 4                     // Receive FIFO depth
) (
   input  wire                          clk,
   input  wire                          rst_n_i,
   input  wire                          stb_i,
   input  wire                          we_i,
   input  wire  [tile_pkg::DATA_W-1:0]  adr_i,
   input  wire  [tile_pkg::DATA_W-1:0]  dat_i,
   output logic [tile_pkg::DATA_W-1:0]  dat_o,
   output logic                         ack_o,
   output logic [tile_pkg::FLIT_W-1:0]  noc_out_flit_o,
   output logic                         noc_out_valid_o,
   input  wire                          noc_out_ready_i,
   input  wire  [tile_pkg::FLIT_W-1:0]  noc_in_flit_i,
   input  wire                          noc_in_valid_i,
   output logic                         noc_in_ready_o,
   output logic                         irq_o
);

   localparam int CNT_W = $clog2(RX_DEPTH) + 1;           // Occupancy width

   logic [7:0]                  reg_off;                  // Register offset
   logic                        seen_q, first;            // Access tracking
   logic                        is_send, is_send_wr;      // Send register hit
   logic                        accept;                   // Flit leaves this cycle
   tile_pkg::flit_type_e        snd_type;
   tile_pkg::flit_data_u        snd_data;
   logic [tile_pkg::FLIT_W-1:0] rx_flit;                  // FIFO head
   logic [CNT_W-1:0]            rx_count;
   logic                        rx_full, rx_empty, rx_push, rx_pop;

   assign reg_off    = adr_i[7:0];
   assign first      = stb_i & ~seen_q;
   assign is_send_wr = is_send & we_i;
   assign accept     = noc_out_valid_o & noc_out_ready_i;
   assign rx_push    = noc_in_valid_i & ~rx_full;
   assign rx_pop     = first & ~we_i & (reg_off == tile_pkg::REG_RX_DATA) & ~rx_empty;

   assign noc_in_ready_o = ~rx_full;
   assign irq_o          = ~rx_empty;                     // Flits waiting

   always_comb begin
      is_send  = 1'b1;
      snd_type = tile_pkg::FLIT_PAYLOAD;
      case (reg_off)
         tile_pkg::REG_SEND_HDR:  snd_type = tile_pkg::FLIT_HEADER;
         tile_pkg::REG_SEND_DATA: snd_type = tile_pkg::FLIT_PAYLOAD;
         tile_pkg::REG_SEND_LAST: snd_type = tile_pkg::FLIT_LAST;
         default:                 is_send  = 1'b0;
      endcase
      snd_data.raw = dat_i;
      if (snd_type == tile_pkg::FLIT_HEADER) begin
         snd_data.hdr.src = TILE_ID;                      // Software cannot forge src
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         seen_q          <= 1'b0;
         ack_o           <= 1'b0;
         noc_out_valid_o <= 1'b0;
      end else begin
         seen_q <= stb_i;
         ack_o  <= (first & ~is_send_wr) | accept;        // Sends ack after handoff
         if (accept) begin
            noc_out_valid_o <= 1'b0;
         end else if (first & is_send_wr) begin
            noc_out_valid_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (first & is_send_wr) begin
         noc_out_flit_o <= {snd_type, snd_data.raw};      // Held until accepted
      end
      if (first & ~we_i) begin
         case (reg_off)
            tile_pkg::REG_RX_DATA: dat_o <= rx_empty ? '0 : rx_flit[tile_pkg::DATA_W-1:0];
            tile_pkg::REG_STATUS:  dat_o <= {{(tile_pkg::DATA_W-10){1'b0}},
                                             rx_flit[tile_pkg::FLIT_W-1 -: 2], 8'(rx_count)};
            default:               dat_o <= '0;
         endcase
      end
   end

   noc_rx_fifo #(
      .RX_DEPTH (RX_DEPTH)
   ) u_rx_fifo (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .push_i  (rx_push),
      .flit_i  (noc_in_flit_i),
      .pop_i   (rx_pop),
      .flit_o  (rx_flit),
      .count_o (rx_count),
      .full_o  (rx_full),
      .empty_o (rx_empty)
   );

   a_out_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      noc_out_valid_o && !noc_out_ready_i |=> noc_out_valid_o && $stable(noc_out_flit_o));

endmodule

`default_nettype wire

/* noc_rx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_rx_fifo #(
   parameter int RX_DEPTH = 4                             // Entries, power of two
) (
   input  wire                                clk,
   input  wire                                rst_n_i,
   input  wire                                push_i,
   input  wire  [tile_pkg::FLIT_W-1:0]        flit_i,
   input  wire                                pop_i,
   output logic [tile_pkg::FLIT_W-1:0]        flit_o,
   output logic [$clog2(RX_DEPTH):0]          count_o,
   output logic                               full_o,
   output logic                               empty_o
);

   localparam int PW = $clog2(RX_DEPTH);                  // Pointer width

   logic [tile_pkg::FLIT_W-1:0] buf_q [RX_DEPTH];         // Whole flits with type
   logic [PW-1:0]               wr_ptr_q, rd_ptr_q;       // Wrap on their own
   logic [PW:0]                 cnt_q;

   assign flit_o  = buf_q[rd_ptr_q];                      // Head visible before pop
   assign count_o = cnt_q;
   assign full_o  = (cnt_q == (PW+1)'(RX_DEPTH));
   assign empty_o = (cnt_q == '0);

   always_ff @(posedge clk) begin
      if (push_i) begin
         buf_q[wr_ptr_q] <= flit_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: cnt_q <= cnt_q;                      // Both or neither
         endcase
      end
   end

   a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(push_i && full_o) && !(pop_i && empty_o));

endmodule

`default_nettype wire

/* bootrom.sv */
`timescale 1ns/1ps
`default_nettype none

module bootrom (
   input  wire                          clk,
   input  wire                          rst_n_i,
   input  wire                          stb_i,
   input  wire  [tile_pkg::DATA_W-1:0]  adr_i,
   output logic [tile_pkg::DATA_W-1:0]  dat_o,
   output logic                         ack_o
);

   logic seen_q;                                          // Access already served
   logic first;                                           // First cycle of an access

   assign first = stb_i & ~seen_q;

   always_ff @(posedge clk) begin
      if (first) begin
         dat_o <= tile_pkg::ROM_TABLE[adr_i[4:2]];        // Aliases every 32 bytes
      end
   end

   // Writes land here too and simply get their ack
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o  <= 1'b0;
         seen_q <= 1'b0;
      end else begin
         ack_o  <= first;
         seen_q <= stb_i;                                 // Cleared when stb drops
      end
   end

endmodule

`default_nettype wire

/* wb_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_sram #(
   parameter int MEM_WORDS = 256                          // Depth in words
) (
   input  wire                          clk,
   input  wire                          rst_n_i,
   input  wire                          stb_i,
   input  wire                          we_i,
   input  wire  [tile_pkg::DATA_W-1:0]  adr_i,
   input  wire  [tile_pkg::DATA_W-1:0]  dat_i,
   input  wire  [tile_pkg::SEL_W-1:0]   sel_i,
   output logic [tile_pkg::DATA_W-1:0]  dat_o,
   output logic                         ack_o
);

   localparam int AW = $clog2(MEM_WORDS);                 // Word index width

   logic [tile_pkg::DATA_W-1:0] mem [MEM_WORDS];
   logic [AW-1:0]               idx;                      // Wraps modulo depth
   logic                        seen_q;                   // Access already served
   logic                        first;                    // First cycle of an access

   assign idx   = adr_i[AW+1:2];
   assign first = stb_i & ~seen_q;

   always_ff @(posedge clk) begin
      if (first) begin
         if (we_i) begin
            for (int b = 0; b < tile_pkg::SEL_W; b++) begin
               if (sel_i[b]) begin
                  mem[idx][8*b +: 8] <= dat_i[8*b +: 8]; // Byte lane write
               end
            end
         end
         dat_o <= mem[idx];                               // Old data on a write
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o  <= 1'b0;
         seen_q <= 1'b0;
      end else begin
         ack_o  <= first;                                 // Single cycle ack
         seen_q <= stb_i;
      end
   end

endmodule

`default_nettype wire

/* wb_bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_bus_decode (
   input  wire                          clk,
   input  wire                          rst_n_i,
   input  wire  [tile_pkg::DATA_W-1:0]  wb_adr_i,
   input  wire                          wb_cyc_i,
   input  wire                          wb_stb_i,
   input  wire                          mem_ack_i,
   input  wire  [tile_pkg::DATA_W-1:0]  mem_dat_i,
   input  wire                          na_ack_i,
   input  wire  [tile_pkg::DATA_W-1:0]  na_dat_i,
   input  wire                          rom_ack_i,
   input  wire  [tile_pkg::DATA_W-1:0]  rom_dat_i,
   output logic                         mem_stb_o,
   output logic                         na_stb_o,
   output logic                         rom_stb_o,
   output logic [tile_pkg::DATA_W-1:0]  wb_dat_o,
   output logic                         wb_ack_o,
   output logic                         wb_err_o
);

   logic [3:0] nib;                                       // Top address nibble
   logic       sel_mem, sel_na, sel_rom, sel_err;         // One-hot slave select
   logic       req;                                       // Live bus request
   logic       err_q;                                     // Error response pulse
   logic       err_seen_q;                                // Request already answered

   assign nib     = wb_adr_i[tile_pkg::DATA_W-1 -: 4];
   assign sel_mem = ~wb_adr_i[tile_pkg::DATA_W-1];        // Lower half of the map
   assign sel_na  = (nib == tile_pkg::NA_BASE_NIB);
   assign sel_rom = (nib == tile_pkg::ROM_BASE_NIB);
   assign sel_err = ~(sel_mem | sel_na | sel_rom);        // Nibbles 8 to D
   assign req     = wb_cyc_i & wb_stb_i;

   assign mem_stb_o = req & sel_mem;
   assign na_stb_o  = req & sel_na;
   assign rom_stb_o = req & sel_rom;

   always_comb begin
      case (1'b1)
         sel_mem: wb_dat_o = mem_dat_i;
         sel_na:  wb_dat_o = na_dat_i;
         sel_rom: wb_dat_o = rom_dat_i;
         default: wb_dat_o = '0;                          // Unmapped reads as zero
      endcase
   end

   assign wb_ack_o = (sel_mem & mem_ack_i) | (sel_na & na_ack_i) | (sel_rom & rom_ack_i);
   assign wb_err_o = err_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q      <= 1'b0;
         err_seen_q <= 1'b0;
      end else begin
         err_q      <= req & sel_err & ~err_seen_q;      // One pulse per access
         err_seen_q <= req;                               // Held until stb drops
      end
   end

   a_one_slave: assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0({mem_stb_o, na_stb_o, rom_stb_o}));

   a_ack_xor_err: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(wb_ack_o && wb_err_o));                           // Slave ack never meets error

endmodule

`default_nettype wire

/* tile_pkg.sv */
`default_nettype none

package tile_pkg;

   localparam int DATA_W      = 32;                   // Bus data and address width
   localparam int SEL_W       = DATA_W / 8;           // Byte lanes
   localparam int FLIT_TYPE_W = 2;                    // Flit type field
   localparam int FLIT_W      = DATA_W + FLIT_TYPE_W; // Type sits in the top bits

   typedef enum logic [FLIT_TYPE_W-1:0] {
      FLIT_PAYLOAD = 2'd0,                            // Body flit
      FLIT_HEADER  = 2'd1,                            // Opens a packet
      FLIT_LAST    = 2'd2,                            // Closes a packet
      FLIT_SINGLE  = 2'd3                             // Header and last in one
   } flit_type_e;

   // Header flits route on the first data word, everything else is raw payload
   typedef union packed {
      struct packed {
         logic [4:0]  dest;                           // Destination tile
         logic [2:0]  pclass;                         // Packet class
         logic [4:0]  src;                            // Sending tile
         logic [18:0] rsvd;                           // Free for software
      } hdr;
      logic [DATA_W-1:0] raw;                         // Plain data word
   } flit_data_u;

   localparam logic [3:0] NA_BASE_NIB  = 4'hE;        // Network adapter window
   localparam logic [3:0] ROM_BASE_NIB = 4'hF;        // Boot ROM window

   localparam logic [7:0] REG_SEND_HDR  = 8'h00;      // Send header flit
   localparam logic [7:0] REG_SEND_DATA = 8'h04;      // Send payload flit
   localparam logic [7:0] REG_SEND_LAST = 8'h08;      // Send last flit
   localparam logic [7:0] REG_RX_DATA   = 8'h0C;      // Pop receive FIFO
   localparam logic [7:0] REG_STATUS    = 8'h10;      // Fill count and head type

   localparam int ROM_WORDS = 8;

   localparam logic [DATA_W-1:0] ROM_TABLE [ROM_WORDS] = '{
      32'h1800_E000,                                  // Adapter base, high half
      32'hA840_0010,                                  // Status offset
      32'h8462_0000,                                  // Poll status
      32'hBC22_0000,                                  // Compare count
      32'h13FF_FFFE,                                  // Spin while empty
      32'h1500_0000,                                  // Delay slot
      32'h4400_4800,                                  // Jump to SRAM entry
      32'h1500_0001                                   // Marker word
   };

endpackage

`default_nettype wire
